/* ooo_isa_pkg.sv */
`default_nettype none

package ooo_isa_pkg;

    // Kept integer operations, register-register first
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_slt  = 4'd5,
        op_addi = 4'd6,
        op_andi = 4'd7,
        op_ori  = 4'd8,
        op_sll  = 4'd9,
        op_srl  = 4'd10
    } opcode_e;

    // Architectural register number
    typedef logic [4:0] reg_idx_t;

    // Data word
    typedef logic [31:0] word_t;

    // Already-fetched instruction as delivered on the issue port
    // Shift amount sits in imm[4:0]
    typedef struct packed {
        opcode_e        opcode;
        reg_idx_t       rd;
        reg_idx_t       rs;
        reg_idx_t       rt;
        logic [15:0]    imm;
    } inst_t;

endpackage

`default_nettype wire

/* ooo_uarch_pkg.sv */
`default_nettype none

package ooo_uarch_pkg;

    // ROB entry number, also the rename tag
    typedef logic [3:0] tag_t;

    // Result bus
    typedef struct packed {
        logic                   valid;
        tag_t                   tag;
        ooo_isa_pkg::word_t     data;
    } cdb_t;

    // Source operand, value only meaningful once ready
    typedef struct packed {
        logic                   ready;
        tag_t                   tag;
        ooo_isa_pkg::word_t     value;
    } operand_t;

    // Retirement record
    typedef struct packed {
        logic                   valid;
        ooo_isa_pkg::reg_idx_t  rd;
        ooo_isa_pkg::word_t     data;
    } commit_t;

    // Reservation station slot, busy doubles as issue valid
    typedef struct packed {
        logic                   busy;
        ooo_isa_pkg::opcode_e   opcode;
        tag_t                   dest;
        operand_t               rs_op;
        operand_t               rt_op;
        ooo_isa_pkg::word_t     imm;
    } rs_entry_t;

endpackage

`default_nettype wire

/* rename_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispatch,
    input  ooo_isa_pkg::reg_idx_t   rs_idx,
    input  ooo_isa_pkg::reg_idx_t   rt_idx,
    input  ooo_isa_pkg::reg_idx_t   rd_idx,
    input  ooo_uarch_pkg::tag_t     alloc_tag,
    input  ooo_uarch_pkg::commit_t  retire,
    input  ooo_uarch_pkg::tag_t     retire_tag,
    output ooo_uarch_pkg::operand_t rs_src,
    output ooo_uarch_pkg::operand_t rt_src
);

    ooo_isa_pkg::word_t     regs [32];
    ooo_uarch_pkg::tag_t    tags [32];
    logic [31:0]            pending;

    // Pending register hands out its producer tag
    function automatic ooo_uarch_pkg::operand_t read_operand(ooo_isa_pkg::reg_idx_t idx);
        ooo_uarch_pkg::operand_t op;
        op.ready = 1'b1;
        op.tag   = '0;
        op.value = '0;
        if (idx != '0) begin
            op.ready = !pending[idx];
            op.tag   = tags[idx];
            op.value = pending[idx] ? '0 : regs[idx];
        end
        return op;
    endfunction

    always_comb begin
        rs_src = read_operand(rs_idx);
        rt_src = read_operand(rt_idx);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (retire.valid && retire.rd != '0) begin
                regs[retire.rd] <= retire.data;
                // Only clear if no younger writer has claimed rd
                if (pending[retire.rd] && tags[retire.rd] == retire_tag) begin
                    pending[retire.rd] <= 1'b0;
                end
            end
            // New mapping overrides the clear above
            if (dispatch && rd_idx != '0) begin
                pending[rd_idx] <= 1'b1;
                tags[rd_idx]    <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
    parameter int rob_depth = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dispatch,
    input  ooo_isa_pkg::inst_t          dispatch_inst,
    input  ooo_uarch_pkg::tag_t         dispatch_tag,
    input  ooo_uarch_pkg::operand_t     rs_operand,
    input  ooo_uarch_pkg::operand_t     rt_operand,
    input  ooo_uarch_pkg::cdb_t         cdb,
    output ooo_uarch_pkg::rs_entry_t    issue
);

    localparam int idx_w = $clog2(rob_depth);
    typedef logic [idx_w-1:0] slot_t;

    ooo_uarch_pkg::rs_entry_t   entries [rob_depth];
    ooo_uarch_pkg::rs_entry_t   new_entry;
    slot_t                      free_idx;
    slot_t                      sel_idx;
    logic                       free_found;
    logic                       sel_found;

    // Build the slot, unused operands are marked ready
    always_comb begin
        new_entry.busy   = 1'b1;
        new_entry.opcode = dispatch_inst.opcode;
        new_entry.dest   = dispatch_tag;
        new_entry.rs_op  = rs_operand;
        new_entry.rt_op  = rt_operand;
        new_entry.imm    = '0;
        case (dispatch_inst.opcode)
            ooo_isa_pkg::op_addi: begin
                new_entry.imm         = {{16{dispatch_inst.imm[15]}}, dispatch_inst.imm};
                new_entry.rt_op.ready = 1'b1;
            end
            ooo_isa_pkg::op_andi, ooo_isa_pkg::op_ori: begin
                new_entry.imm         = {16'd0, dispatch_inst.imm};
                new_entry.rt_op.ready = 1'b1;
            end
            ooo_isa_pkg::op_sll, ooo_isa_pkg::op_srl: begin
                new_entry.imm         = {27'd0, dispatch_inst.imm[4:0]};
                new_entry.rs_op.ready = 1'b1;
            end
            default: begin
                new_entry.imm = '0;
            end
        endcase
    end

    // Lowest free slot and lowest ready slot
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        sel_idx    = '0;
        sel_found  = 1'b0;
        for (int i = 0; i < rob_depth; i++) begin
            if (!entries[i].busy && !free_found) begin
                free_idx   = slot_t'(i);
                free_found = 1'b1;
            end
            if (entries[i].busy && entries[i].rs_op.ready && entries[i].rt_op.ready
                    && !sel_found) begin
                sel_idx   = slot_t'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign issue = sel_found ? entries[sel_idx] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rob_depth; i++) begin
                entries[i].busy <= 1'b0;
            end
        end else begin
            for (int i = 0; i < rob_depth; i++) begin
                if (sel_found && sel_idx == slot_t'(i)) begin
                    entries[i].busy <= 1'b0;
                end
                // Wakeup from the result bus
                if (cdb.valid && !entries[i].rs_op.ready && entries[i].rs_op.tag == cdb.tag) begin
                    entries[i].rs_op.ready <= 1'b1;
                    entries[i].rs_op.value <= cdb.data;
                end
                if (cdb.valid && !entries[i].rt_op.ready && entries[i].rt_op.tag == cdb.tag) begin
                    entries[i].rt_op.ready <= 1'b1;
                    entries[i].rt_op.value <= cdb.data;
                end
                if (dispatch && free_found && free_idx == slot_t'(i)) begin
                    entries[i] <= new_entry;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  ooo_uarch_pkg::rs_entry_t    issue,
    output ooo_uarch_pkg::cdb_t         cdb
);

    ooo_isa_pkg::word_t a;
    ooo_isa_pkg::word_t b;
    ooo_isa_pkg::word_t result;

    assign a = issue.rs_op.value;
    assign b = issue.rt_op.value;

    always_comb begin
        case (issue.opcode)
            ooo_isa_pkg::op_add:  result = a + b;
            ooo_isa_pkg::op_sub:  result = a - b;
            ooo_isa_pkg::op_and:  result = a & b;
            ooo_isa_pkg::op_or:   result = a | b;
            ooo_isa_pkg::op_xor:  result = a ^ b;
            ooo_isa_pkg::op_slt:  result = {31'd0, $signed(a) < $signed(b)};
            ooo_isa_pkg::op_addi: result = a + issue.imm;
            ooo_isa_pkg::op_andi: result = a & issue.imm;
            ooo_isa_pkg::op_ori:  result = a | issue.imm;
            // Shifts act on rt
            ooo_isa_pkg::op_sll:  result = b << issue.imm[4:0];
            ooo_isa_pkg::op_srl:  result = b >> issue.imm[4:0];
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue.busy;
            cdb.tag   <= issue.dest;
            cdb.data  <= result;
        end
    end

endmodule

`default_nettype wire

/* reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int rob_depth = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dispatch,
    input  ooo_isa_pkg::reg_idx_t       dispatch_rd,
    output ooo_uarch_pkg::tag_t         alloc_tag,
    input  ooo_uarch_pkg::operand_t     rs_src,
    input  ooo_uarch_pkg::operand_t     rt_src,
    output ooo_uarch_pkg::operand_t     rs_operand,
    output ooo_uarch_pkg::operand_t     rt_operand,
    input  ooo_uarch_pkg::cdb_t         cdb,
    output ooo_uarch_pkg::commit_t      commit,
    output ooo_uarch_pkg::tag_t         commit_tag,
    output logic                        credit_return
);

    localparam int ptr_w = $clog2(rob_depth);

    ooo_uarch_pkg::tag_t    head;
    ooo_uarch_pkg::tag_t    tail;
    logic [4:0]             count;
    logic                   done [rob_depth];
    ooo_isa_pkg::reg_idx_t  rd_q [rob_depth];
    ooo_isa_pkg::word_t     data_q [rob_depth];
    logic                   retire_now;

    function automatic logic [ptr_w-1:0] slot(ooo_uarch_pkg::tag_t t);
        return t[ptr_w-1:0];
    endfunction

    function automatic ooo_uarch_pkg::tag_t next_ptr(ooo_uarch_pkg::tag_t p);
        return (p == ooo_uarch_pkg::tag_t'(rob_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // Done stays set after retire so a lookup in the commit cycle still hits
    function automatic ooo_uarch_pkg::operand_t resolve(ooo_uarch_pkg::operand_t src);
        ooo_uarch_pkg::operand_t op;
        op = src;
        if (!src.ready) begin
            if (done[slot(src.tag)]) begin
                op.ready = 1'b1;
                op.value = data_q[slot(src.tag)];
            end else if (cdb.valid && cdb.tag == src.tag) begin
                op.ready = 1'b1;
                op.value = cdb.data;
            end
        end
        return op;
    endfunction

    always_comb begin
        rs_operand = resolve(rs_src);
        rt_operand = resolve(rt_src);
    end

    assign alloc_tag  = tail;
    assign retire_now = (count != '0) && done[slot(head)];

    always_ff @(posedge clk) begin
        if (rst) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            commit.valid  <= 1'b0;
            credit_return <= 1'b0;
            for (int i = 0; i < rob_depth; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            if (dispatch) begin
                done[slot(tail)] <= 1'b0;
                rd_q[slot(tail)] <= dispatch_rd;
                tail             <= next_ptr(tail);
            end
            // Completion from the result bus
            if (cdb.valid) begin
                done[slot(cdb.tag)]   <= 1'b1;
                data_q[slot(cdb.tag)] <= cdb.data;
            end
            // Head retires in order
            commit.valid  <= retire_now;
            credit_return <= retire_now;
            commit.rd     <= rd_q[slot(head)];
            commit.data   <= data_q[slot(head)];
            commit_tag    <= head;
            if (retire_now) begin
                head <= next_ptr(head);
            end
            count <= count + 5'(dispatch) - 5'(retire_now);
        end
    end

endmodule

`default_nettype wire

/* ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core #(
    parameter int rob_depth = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  ooo_isa_pkg::inst_t      issue_inst,
    output logic                    credit_return,
    output ooo_uarch_pkg::commit_t  commit
);

    ooo_uarch_pkg::tag_t        alloc_tag;
    ooo_uarch_pkg::tag_t        commit_tag;
    ooo_uarch_pkg::operand_t    rs_src;
    ooo_uarch_pkg::operand_t    rt_src;
    ooo_uarch_pkg::operand_t    rs_operand;
    ooo_uarch_pkg::operand_t    rt_operand;
    ooo_uarch_pkg::rs_entry_t   alu_issue;
    ooo_uarch_pkg::cdb_t        cdb;

    rename_regfile u_rename (
        .clk        (clk),
        .rst        (rst),
        .dispatch   (issue_valid),
        .rs_idx     (issue_inst.rs),
        .rt_idx     (issue_inst.rt),
        .rd_idx     (issue_inst.rd),
        .alloc_tag  (alloc_tag),
        .retire     (commit),
        .retire_tag (commit_tag),
        .rs_src     (rs_src),
        .rt_src     (rt_src)
    );

    reorder_buffer #(.rob_depth(rob_depth)) u_rob (
        .clk           (clk),
        .rst           (rst),
        .dispatch      (issue_valid),
        .dispatch_rd   (issue_inst.rd),
        .alloc_tag     (alloc_tag),
        .rs_src        (rs_src),
        .rt_src        (rt_src),
        .rs_operand    (rs_operand),
        .rt_operand    (rt_operand),
        .cdb           (cdb),
        .commit        (commit),
        .commit_tag    (commit_tag),
        .credit_return (credit_return)
    );

    reservation_station #(.rob_depth(rob_depth)) u_rs (
        .clk           (clk),
        .rst           (rst),
        .dispatch      (issue_valid),
        .dispatch_inst (issue_inst),
        .dispatch_tag  (alloc_tag),
        .rs_operand    (rs_operand),
        .rt_operand    (rt_operand),
        .cdb           (cdb),
        .issue         (alu_issue)
    );

    alu_unit u_alu (
        .clk   (clk),
        .rst   (rst),
        .issue (alu_issue),
        .cdb   (cdb)
    );

endmodule

`default_nettype wire

/* tb_ooo_tests.svh */
// Xorshift generator for the random stream
function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic ooo_isa_pkg::inst_t make_inst(input ooo_isa_pkg::opcode_e op,
        input int rd, input int rs, input int rt, input int imm);
    ooo_isa_pkg::inst_t inst;
    inst.opcode = op;
    inst.rd     = 5'(rd);
    inst.rs     = 5'(rs);
    inst.rt     = 5'(rt);
    inst.imm    = 16'(imm);
    return inst;
endfunction

// Architectural result of one instruction
function automatic ooo_isa_pkg::word_t model_result(input ooo_isa_pkg::inst_t inst,
        input ooo_isa_pkg::word_t a, input ooo_isa_pkg::word_t b);
    ooo_isa_pkg::word_t simm;
    ooo_isa_pkg::word_t zimm;
    simm = 32'($signed(inst.imm));
    zimm = 32'(inst.imm);
    case (inst.opcode)
        ooo_isa_pkg::op_add:  return a + b;
        ooo_isa_pkg::op_sub:  return a - b;
        ooo_isa_pkg::op_and:  return a & b;
        ooo_isa_pkg::op_or:   return a | b;
        ooo_isa_pkg::op_xor:  return a ^ b;
        ooo_isa_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ooo_isa_pkg::op_addi: return a + simm;
        ooo_isa_pkg::op_andi: return a & zimm;
        ooo_isa_pkg::op_ori:  return a | zimm;
        ooo_isa_pkg::op_sll:  return b << inst.imm[4:0];
        ooo_isa_pkg::op_srl:  return b >> inst.imm[4:0];
        default:              return '0;
    endcase
endfunction

// Waits for a credit, then drives one instruction for one cycle
task automatic send_inst(input ooo_isa_pkg::inst_t inst);
    ooo_uarch_pkg::commit_t exp;
    int waited;
    waited = 0;
    while (credits() == 0 && waited < wait_limit) begin
        @(posedge clk);
        #1;
        waited++;
    end
    if (credits() == 0) begin
        abort_run("Timed out waiting for a credit to come back");
    end
    exp.valid = 1'b1;
    exp.rd    = inst.rd;
    exp.data  = model_result(inst, model_regs[inst.rs], model_regs[inst.rt]);
    expected_q.push_back(exp);
    if (inst.rd != 5'd0) begin
        model_regs[inst.rd] = exp.data;
    end
    issue_valid = 1'b1;
    issue_inst  = inst;
    issued++;
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
    issue_inst  = '0;
endtask

task automatic load_const(input int rd, input logic [31:0] value);
    send_inst(make_inst(ooo_isa_pkg::op_ori, rd, 0, 0, int'(value[31:16])));
    send_inst(make_inst(ooo_isa_pkg::op_sll, rd, 0, rd, 16));
    send_inst(make_inst(ooo_isa_pkg::op_ori, rd, rd, 0, int'(value[15:0])));
endtask

task automatic wait_drained();
    int waited;
    waited = 0;
    while ((expected_q.size() != 0 || credits() != rob_depth) && waited < wait_limit) begin
        @(posedge clk);
        #1;
        waited++;
    end
    if (expected_q.size() != 0) begin
        abort_run("Timed out waiting for outstanding instructions to commit");
    end
    check_count("credits", credits(), rob_depth);
endtask

task automatic idle_after_reset();
    for (int i = 0; i < 10; i++) begin
        @(negedge clk);
        check_flag("commit.valid", commit.valid, 1'b0);
        check_flag("credit_return", credit_return, 1'b0);
        @(posedge clk);
        #1;
    end
    check_count("credits", credits(), rob_depth);
endtask

task automatic exercise_all_opcodes();
    load_const(1, 32'hfffffff0);
    load_const(2, 32'h00000005);
    load_const(3, 32'h80000001);
    send_inst(make_inst(ooo_isa_pkg::op_add, 4, 1, 2, 0));
    send_inst(make_inst(ooo_isa_pkg::op_sub, 5, 2, 1, 0));
    send_inst(make_inst(ooo_isa_pkg::op_and, 6, 1, 3, 0));
    send_inst(make_inst(ooo_isa_pkg::op_or, 7, 2, 3, 0));
    send_inst(make_inst(ooo_isa_pkg::op_xor, 8, 1, 2, 0));
    // Signed compare in both directions
    send_inst(make_inst(ooo_isa_pkg::op_slt, 9, 1, 2, 0));
    send_inst(make_inst(ooo_isa_pkg::op_slt, 10, 2, 1, 0));
    send_inst(make_inst(ooo_isa_pkg::op_slt, 11, 3, 2, 0));
    send_inst(make_inst(ooo_isa_pkg::op_addi, 12, 2, 0, 16'hfff0));
    send_inst(make_inst(ooo_isa_pkg::op_andi, 13, 1, 0, 16'hff0f));
    send_inst(make_inst(ooo_isa_pkg::op_ori, 14, 2, 0, 16'h8000));
    send_inst(make_inst(ooo_isa_pkg::op_sll, 15, 0, 2, 3));
    send_inst(make_inst(ooo_isa_pkg::op_srl, 16, 0, 1, 4));
    wait_drained();
endtask

task automatic follow_dependency_chains();
    send_inst(make_inst(ooo_isa_pkg::op_addi, 1, 0, 0, 3));
    repeat (5) send_inst(make_inst(ooo_isa_pkg::op_add, 1, 1, 1, 0));
    send_inst(make_inst(ooo_isa_pkg::op_sub, 2, 0, 1, 0));
    send_inst(make_inst(ooo_isa_pkg::op_slt, 3, 2, 1, 0));
    send_inst(make_inst(ooo_isa_pkg::op_sll, 4, 0, 1, 4));
    send_inst(make_inst(ooo_isa_pkg::op_xor, 5, 4, 2, 0));
    send_inst(make_inst(ooo_isa_pkg::op_srl, 6, 0, 5, 1));
    send_inst(make_inst(ooo_isa_pkg::op_or, 7, 6, 3, 0));
    wait_drained();
endtask

// Younger independent work finishes first, commits must not
task automatic commit_in_program_order();
    send_inst(make_inst(ooo_isa_pkg::op_addi, 20, 0, 0, 1));
    repeat (4) send_inst(make_inst(ooo_isa_pkg::op_addi, 20, 20, 0, 7));
    send_inst(make_inst(ooo_isa_pkg::op_ori, 21, 0, 0, 16'h0055));
    send_inst(make_inst(ooo_isa_pkg::op_andi, 22, 1, 0, 16'h00ff));
    send_inst(make_inst(ooo_isa_pkg::op_addi, 23, 0, 0, 16'hfffe));
    wait_drained();
endtask

task automatic write_register_zero();
    send_inst(make_inst(ooo_isa_pkg::op_addi, 0, 0, 0, 123));
    send_inst(make_inst(ooo_isa_pkg::op_add, 0, 1, 2, 0));
    send_inst(make_inst(ooo_isa_pkg::op_add, 24, 0, 0, 0));
    send_inst(make_inst(ooo_isa_pkg::op_or, 25, 0, 2, 0));
    send_inst(make_inst(ooo_isa_pkg::op_sll, 26, 0, 0, 3));
    wait_drained();
endtask

// Small register range keeps dependencies frequent
task automatic stream_random_instructions();
    logic [31:0] r;
    ooo_isa_pkg::opcode_e op;
    for (int n = 0; n < 300; n++) begin
        r  = next_random();
        op = ooo_isa_pkg::opcode_e'(4'(r % 32'd11));
        send_inst(make_inst(op, int'(r[6:4]), int'(r[9:7]), int'(r[12:10]), int'(r[31:16])));
    end
    wait_drained();
    check_count("commits", commits_seen, issued);
endtask

/* tb_ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;

    localparam int rob_depth  = 8;
    localparam int wait_limit = 200;

    logic                       clk;
    logic                       rst;
    logic                       issue_valid;
    ooo_isa_pkg::inst_t         issue_inst;
    logic                       credit_return;
    ooo_uarch_pkg::commit_t     commit;

    // Reference model updated in issue order
    ooo_isa_pkg::word_t         model_regs [32];
    ooo_uarch_pkg::commit_t     expected_q [$];
    int                         issued;
    int                         returned;
    int                         commits_seen;
    logic [31:0]                rng_state;

    ooo_core #(.rob_depth(rob_depth)) u_dut (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_inst    (issue_inst),
        .credit_return (credit_return),
        .commit        (commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_commit(input ooo_uarch_pkg::commit_t actual,
                                input ooo_uarch_pkg::commit_t expected);
        if (actual !== expected) begin
            abort_run($sformatf(
                "ERROR t=%0t commit: got valid=%b rd=%0d data=%h, expected valid=%b rd=%0d data=%h",
                $time, actual.valid, actual.rd, actual.data,
                expected.valid, expected.rd, expected.data));
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            abort_run($sformatf("ERROR t=%0t %s: got %0d, expected %0d",
                                $time, name, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR t=%0t %s: got %b, expected %b",
                                $time, name, actual, expected));
        end
    endtask

    // Credits still held by the testbench
    function automatic int credits();
        return rob_depth - issued + returned;
    endfunction

    // Commit port monitor sampled at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (rst === 1'b0) begin
                check_flag("credit_return", credit_return, commit.valid);
                if (credit_return === 1'b1) begin
                    returned++;
                end
                if (commit.valid === 1'b1) begin
                    if (expected_q.size() == 0) begin
                        abort_run("A commit arrived while no instruction was outstanding");
                    end else begin
                        check_commit(commit, expected_q.pop_front());
                    end
                    commits_seen++;
                end
            end
        end
    end

`include "tb_ooo_tests.svh"

    initial begin
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue_inst   = '0;
        issued       = 0;
        returned     = 0;
        commits_seen = 0;
        rng_state    = 32'hb711;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_after_reset();
        exercise_all_opcodes();
        follow_dependency_chains();
        commit_in_program_order();
        write_register_zero();
        stream_random_instructions();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
ooo_isa_pkg.sv
ooo_uarch_pkg.sv
rename_regfile.sv
reservation_station.sv
alu_unit.sv
reorder_buffer.sv
ooo_core.sv
tb_ooo_core.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

if ! verilator --binary --timing -f compile.f --top-module tb_ooo_core -o tb_ooo_core; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ooo_core > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
